// ==== design/iccm_pkg.sv ====
//************************************************
// Geometry and codeword types shared by the ICCM.
// A line is always four 32-bit words.
//************************************************

package iccm_pkg;

   localparam int ICCM_LANES  = 4;
   localparam int ICCM_DATA_W = 32;
   localparam int ICCM_ECC_W  = 7;

   // Stored 39-bit codeword, check bits on top
   typedef struct packed {
      logic [ICCM_ECC_W-1:0]  ecc;
      logic [ICCM_DATA_W-1:0] data;
   } iccm_word_t;

   typedef struct packed {
      logic correct_en;
      logic inj_single;
      logic inj_double;
   } iccm_cfg_t;

   // iccm_err_t is declared where ADDR_W is known, fields MSB first:
   //    single_err, double_err, line_addr[ADDR_W-3:0]

   // Hamming check bits 0..5 over data placed at positions 3..38
   function automatic logic [5:0] ecc_hamming(logic [ICCM_DATA_W-1:0] data);
      logic [5:0] chk;
      int         j;
      chk = '0;
      j   = 0;
      for (int p = 3; p < 39; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int k = 0; k < 6; k++) begin
               if (((p >> k) & 1) != 0) begin
                  chk[k] = chk[k] ^ data[j];
               end
            end
            j++;
         end
      end
      return chk;
   endfunction

endpackage

// ==== design/iccm_ram.sv ====
//************************************************
// One lane of one bank, single port.
// Read and write in the same cycle is not supported.
//************************************************
`timescale 1ns/1ps

module iccm_ram
   import iccm_pkg::*;
#(
   parameter int DEPTH = 512
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] adr,
   input  iccm_word_t               d,
   output iccm_word_t               q
);

   iccm_word_t mem [DEPTH];

   // Output register follows the address unless a write is in progress
   always_ff @(posedge clk) begin
      if (we) begin
         mem[adr] <= d;
      end else begin
         q <= mem[adr];
      end
   end

endmodule

// ==== design/iccm_ecc_gen.sv ====
//************************************************
// SECDED encode of one word. Injection flips codeword
// bit 0, or bits 0 and 1 when inject_two is set.
//************************************************
`timescale 1ns/1ps

module iccm_ecc_gen
   import iccm_pkg::*;
(
   input  logic [ICCM_DATA_W-1:0] data,
   input  logic                   inject_one,
   input  logic                   inject_two,
   output iccm_word_t             word
);

   iccm_word_t clean;
   logic [1:0] flip;

   always_comb begin
      clean.data     = data;
      clean.ecc[5:0] = ecc_hamming(data);
      // Overall parity covers data and the six Hamming bits
      clean.ecc[6]   = ^{data, clean.ecc[5:0]};
   end

   // double injection wins over single
   assign flip[0] = inject_one | inject_two;
   assign flip[1] = inject_two;

   always_comb begin
      word      = clean;
      word[1:0] = clean[1:0] ^ flip;
   end

endmodule

// ==== design/iccm_ecc_chk.sv ====
//************************************************
// SECDED check of one codeword, purely combinational.
// Double errors always pass the data through raw.
//************************************************
`timescale 1ns/1ps

module iccm_ecc_chk
   import iccm_pkg::*;
(
   input  iccm_word_t             word,
   input  logic                   correct_en,
   output logic [ICCM_DATA_W-1:0] data,
   output logic                   single_err,
   output logic                   double_err
);

   logic [5:0] syndrome;
   logic       parity_err;

   assign syndrome   = word.ecc[5:0] ^ ecc_hamming(word.data);
   // Clean codewords have even parity over all 39 bits
   assign parity_err = ^word;

   //************************************************
   // Classification
   //************************************************

   // Zero syndrome with bad parity means check bit 6 flipped
   assign single_err = parity_err;
   assign double_err = (syndrome != 6'd0) & ~parity_err;

   //************************************************
   // Correction
   //************************************************

   always_comb begin
      int j;
      j    = 0;
      data = word.data;
      for (int p = 3; p < 39; p++) begin
         if ((p & (p - 1)) != 0) begin
            // Check-bit positions need no data fix
            if (correct_en && single_err && (syndrome == 6'(p))) begin
               data[j] = ~word.data[j];
            end
            j++;
         end
      end
   end

endmodule

// ==== design/iccm_mem.sv ====
//************************************************
// Banked ICCM array, four lanes per bank, one cycle
// read latency. BANK_BITS of 0 gives a single bank.
//************************************************
`timescale 1ns/1ps

module iccm_mem
   import iccm_pkg::*;
#(
   parameter int ADDR_W    = 12,
   parameter int BANK_BITS = 1
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         wr_en,
   input  logic                         rd_en,
   input  logic [ADDR_W-1:0]            addr,
   input  logic                         wr_dword,
   input  iccm_word_t                   wr_lo,
   input  iccm_word_t                   wr_hi,
   output iccm_word_t [ICCM_LANES-1:0]  rd_words,
   output logic                         rd_valid,
   output logic [ADDR_W-3:0]            rd_line_addr
);

   localparam int NUM_BANKS = 1 << BANK_BITS;
   localparam int SEL_W     = (BANK_BITS > 0) ? BANK_BITS : 1;
   localparam int ROW_W     = ADDR_W - 2 - BANK_BITS;
   localparam int DEPTH     = 1 << ROW_W;

   logic [SEL_W-1:0]      addr_bank;
   logic [SEL_W-1:0]      rd_bank_q;
   logic [ROW_W-1:0]      row;
   logic [ADDR_W-3:0]     rd_line_q;
   logic                  rd_valid_q;
   logic                  wren_lo0;
   logic                  wren_lo1;
   logic                  wren_hi0;
   logic                  wren_hi1;
   logic [ICCM_LANES-1:0] lane_we;
   iccm_word_t            odd_d;

   iccm_word_t [NUM_BANKS-1:0][ICCM_LANES-1:0] bank_q;

   //************************************************
   // Address split and write decode
   //************************************************

   if (BANK_BITS > 0) begin : g_bank_sel
      assign addr_bank = addr[2 +: SEL_W];
   end else begin : g_one_bank
      assign addr_bank = '0;
   end

   assign row = addr[ADDR_W-1 : 2+BANK_BITS];

   // hi/lo picks the lane pair, 0/1 the word within it
   assign wren_lo0 = wr_en & ~addr[1] & (~addr[0] | wr_dword);
   assign wren_lo1 = wr_en & ~addr[1] & ( addr[0] | wr_dword);
   assign wren_hi0 = wr_en &  addr[1] & (~addr[0] | wr_dword);
   assign wren_hi1 = wr_en &  addr[1] & ( addr[0] | wr_dword);

   assign lane_we = {wren_hi1, wren_hi0, wren_lo1, wren_lo0};

   // A single word always comes through the low encoder
   assign odd_d = wr_dword ? wr_hi : wr_lo;

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      for (genvar l = 0; l < ICCM_LANES; l++) begin : g_lane
         iccm_ram #(
            .DEPTH (DEPTH)
         ) u_ram (
            .clk (clk),
            .we  (lane_we[l] & (addr_bank == SEL_W'(b))),
            .adr (row),
            .d   ((l % 2 == 1) ? odd_d : wr_lo),
            .q   (bank_q[b][l])
         );
      end
   end

   //************************************************
   // Read side
   //************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_en;
      end
   end

   // Held per read so back-to-back reads keep their own bank
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_bank_q <= addr_bank;
         rd_line_q <= addr[ADDR_W-1:2];
      end
   end

   assign rd_words     = bank_q[rd_bank_q];
   assign rd_valid     = rd_valid_q;
   assign rd_line_addr = rd_line_q;

endmodule

// ==== design/iccm_csr.sv ====
//************************************************
// Control, error counters and last error address.
// Counters saturate, any write to them clears.
//************************************************
`timescale 1ns/1ps

module iccm_csr
   import iccm_pkg::*;
#(
   parameter int ADDR_W = 12
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   csr_wr,
   input  logic [1:0]             csr_addr,
   input  logic [ICCM_DATA_W-1:0] csr_wdata,
   output logic [ICCM_DATA_W-1:0] csr_rdata,
   input  logic                   wr_en,
   input  logic                   err_valid,
   input  logic [ADDR_W-1:0]      err,
   output iccm_cfg_t              cfg
);

   typedef struct packed {
      logic              single_err;
      logic              double_err;
      logic [ADDR_W-3:0] line_addr;
   } iccm_err_t;

   localparam logic [1:0] REG_CTRL     = 2'd0;
   localparam logic [1:0] REG_SB_COUNT = 2'd1;
   localparam logic [1:0] REG_DB_COUNT = 2'd2;
   localparam logic [1:0] REG_ERR_ADDR = 2'd3;

   iccm_err_t              err_in;
   iccm_err_t              err_q;
   logic                   err_valid_q;
   logic [ICCM_DATA_W-1:0] sb_count;
   logic [ICCM_DATA_W-1:0] db_count;
   logic [ADDR_W-3:0]      err_addr;

   assign err_in = err;

   //************************************************
   // CTRL
   //************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg.correct_en <= 1'b1;
         cfg.inj_single <= 1'b0;
         cfg.inj_double <= 1'b0;
      end else begin
         // Injection is one-shot, consumed by the next write
         if (wr_en) begin
            cfg.inj_single <= 1'b0;
            cfg.inj_double <= 1'b0;
         end
         if (csr_wr && (csr_addr == REG_CTRL)) begin
            cfg.correct_en <= csr_wdata[0];
            cfg.inj_single <= csr_wdata[1];
            cfg.inj_double <= csr_wdata[2];
         end
      end
   end

   //************************************************
   // Error tracking, one cycle behind the read data
   //************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         err_valid_q <= 1'b0;
      end else begin
         err_valid_q <= err_valid;
      end
   end

   always_ff @(posedge clk) begin
      err_q <= err_in;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         sb_count <= '0;
         db_count <= '0;
         err_addr <= '0;
      end else begin
         if (err_valid_q && err_q.single_err && !err_q.double_err && (sb_count != '1)) begin
            sb_count <= sb_count + 1'b1;
         end
         if (err_valid_q && err_q.double_err && (db_count != '1)) begin
            db_count <= db_count + 1'b1;
         end
         if (err_valid_q && (err_q.single_err || err_q.double_err)) begin
            err_addr <= err_q.line_addr;
         end
         // clear on write wins over a same-cycle update
         if (csr_wr) begin
            case (csr_addr)
               REG_SB_COUNT: sb_count <= '0;
               REG_DB_COUNT: db_count <= '0;
               REG_ERR_ADDR: err_addr <= '0;
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (csr_addr)
         REG_CTRL: csr_rdata = {29'd0, cfg.inj_double, cfg.inj_single, cfg.correct_en};
         REG_SB_COUNT: csr_rdata = sb_count;
         REG_DB_COUNT: csr_rdata = db_count;
         default: csr_rdata = ICCM_DATA_W'(err_addr);
      endcase
   end

endmodule

// ==== design/iccm_top.sv ====
//************************************************
// ICCM subsystem top. Read data one cycle after rd_en;
// a read and a write in the same cycle is not allowed.
//************************************************
`timescale 1ns/1ps

module iccm_top
   import iccm_pkg::*;
#(
   parameter int ADDR_W    = 12,
   parameter int BANK_BITS = 1
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              wr_en,
   input  logic                              rd_en,
   input  logic [ADDR_W-1:0]                 addr,
   input  logic                              wr_dword,
   input  logic [2*ICCM_DATA_W-1:0]          wr_data,
   output logic [ICCM_LANES*ICCM_DATA_W-1:0] rd_data,
   output logic                              rd_valid,
   output logic                              rd_single_err,
   output logic                              rd_double_err,
   input  logic                              csr_wr,
   input  logic [1:0]                        csr_addr,
   input  logic [ICCM_DATA_W-1:0]            csr_wdata,
   output logic [ICCM_DATA_W-1:0]            csr_rdata
);

   typedef struct packed {
      logic              single_err;
      logic              double_err;
      logic [ADDR_W-3:0] line_addr;
   } iccm_err_t;

   iccm_cfg_t                   cfg;
   iccm_word_t                  wr_lo;
   iccm_word_t                  wr_hi;
   iccm_word_t [ICCM_LANES-1:0] rd_words;
   logic [ADDR_W-3:0]           rd_line_addr;
   logic [ICCM_LANES-1:0]       lane_single;
   logic [ICCM_LANES-1:0]       lane_double;
   iccm_err_t                   err;

   // Only the low half ever carries injected errors
   iccm_ecc_gen u_gen_lo (
      .data       (wr_data[ICCM_DATA_W-1:0]),
      .inject_one (cfg.inj_single),
      .inject_two (cfg.inj_double),
      .word       (wr_lo)
   );

   iccm_ecc_gen u_gen_hi (
      .data       (wr_data[2*ICCM_DATA_W-1:ICCM_DATA_W]),
      .inject_one (1'b0),
      .inject_two (1'b0),
      .word       (wr_hi)
   );

   iccm_mem #(
      .ADDR_W    (ADDR_W),
      .BANK_BITS (BANK_BITS)
   ) u_mem (
      .clk          (clk),
      .reset        (reset),
      .wr_en        (wr_en),
      .rd_en        (rd_en),
      .addr         (addr),
      .wr_dword     (wr_dword),
      .wr_lo        (wr_lo),
      .wr_hi        (wr_hi),
      .rd_words     (rd_words),
      .rd_valid     (rd_valid),
      .rd_line_addr (rd_line_addr)
   );

   for (genvar l = 0; l < ICCM_LANES; l++) begin : g_chk
      iccm_ecc_chk u_chk (
         .word       (rd_words[l]),
         .correct_en (cfg.correct_en),
         .data       (rd_data[l*ICCM_DATA_W +: ICCM_DATA_W]),
         .single_err (lane_single[l]),
         .double_err (lane_double[l])
      );
   end

   // Flags only mean something while the line is valid
   assign rd_single_err = rd_valid & (|lane_single);
   assign rd_double_err = rd_valid & (|lane_double);

   assign err.single_err = |lane_single;
   assign err.double_err = |lane_double;
   assign err.line_addr  = rd_line_addr;

   iccm_csr #(
      .ADDR_W (ADDR_W)
   ) u_csr (
      .clk       (clk),
      .reset     (reset),
      .csr_wr    (csr_wr),
      .csr_addr  (csr_addr),
      .csr_wdata (csr_wdata),
      .csr_rdata (csr_rdata),
      .wr_en     (wr_en),
      .err_valid (rd_valid),
      .err       (err),
      .cfg       (cfg)
   );

endmodule

// ==== dv/iccm_model.svh ====
//**************************************************
// SECDED reference model and shadow memory for the
// ICCM testbench. Shadow covers word addresses 0..63.
//**************************************************

localparam int SHADOW_WORDS = 64;

// Stored codewords, {ecc, data} as held in the RAM
logic [38:0] shadow [SHADOW_WORDS];

// Codeword position of data bit i, skipping powers of two
function automatic int data_pos(input int i);
   int pos;
   int cnt;
   pos = 2;
   cnt = -1;
   while (cnt < i) begin
      pos++;
      if ((pos & (pos - 1)) != 0) begin
         cnt++;
      end
   end
   return pos;
endfunction

// Hamming checks are the XOR of the positions of all set data bits
function automatic logic [5:0] model_checks(input logic [31:0] d);
   logic [5:0] c;
   c = '0;
   for (int i = 0; i < 32; i++) begin
      if (d[i]) begin
         c = c ^ 6'(data_pos(i));
      end
   end
   return c;
endfunction

function automatic logic [38:0] model_encode(input logic [31:0] d);
   logic [5:0] c;
   c = model_checks(d);
   return {^{d, c}, c, d};
endfunction

// Result is {double, single, data}
function automatic logic [33:0] model_decode(input logic [38:0] w, input logic correct);
   logic [5:0]  syn;
   logic        par;
   logic [31:0] d;
   syn = w[37:32] ^ model_checks(w[31:0]);
   par = ^w;
   d   = w[31:0];
   if (correct && par) begin
      for (int i = 0; i < 32; i++) begin
         if (6'(data_pos(i)) == syn) begin
            d[i] = ~d[i];
         end
      end
   end
   return {(syn != 6'd0) && !par, par, d};
endfunction

// ==== dv/iccm_tb.sv ====
//**************************************************
// ICCM subsystem testbench. Stimulus stays in word
// addresses 0..63, which are filled before any read.
//**************************************************
`timescale 1ns/1ps

module iccm_tb
   import iccm_pkg::*;
();

   localparam int ADDR_W    = 12;
   localparam int BANK_BITS = 1;

   typedef struct packed {
      logic         dbl;
      logic         sgl;
      logic [127:0] data;
   } exp_t;

   logic                clk;
   logic                reset;
   logic                wr_en;
   logic                rd_en;
   logic [ADDR_W-1:0]   addr;
   logic                wr_dword;
   logic [63:0]         wr_data;
   logic [127:0]        rd_data;
   logic                rd_valid;
   logic                rd_single_err;
   logic                rd_double_err;
   logic                csr_wr;
   logic [1:0]          csr_addr;
   logic [31:0]         csr_wdata;
   logic [31:0]         csr_rdata;
   integer              seed;
   logic                correct_en_m;
   logic                inj_single_m;
   logic                inj_double_m;
   logic                rd_en_prev;
   exp_t                exp_q[$];

   `include "iccm_model.svh"

   iccm_top #(
      .ADDR_W    (ADDR_W),
      .BANK_BITS (BANK_BITS)
   ) uut (
      .clk           (clk),
      .reset         (reset),
      .wr_en         (wr_en),
      .rd_en         (rd_en),
      .addr          (addr),
      .wr_dword      (wr_dword),
      .wr_data       (wr_data),
      .rd_data       (rd_data),
      .rd_valid      (rd_valid),
      .rd_single_err (rd_single_err),
      .rd_double_err (rd_double_err),
      .csr_wr        (csr_wr),
      .csr_addr      (csr_addr),
      .csr_wdata     (csr_wdata),
      .csr_rdata     (csr_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_val(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected %h actual %h", name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic fail_now(input string what);
      $display("ERROR: %s", what);
      $display("RESULT: FAIL");
      $fatal(1, "Run aborted");
   endtask

   function automatic logic [31:0] fill_pattern(input int a);
      return (32'(a) * 32'h9E37_79B1) + 32'h0BAD_F00D;
   endfunction

   // Only the low encoder sees the armed injection
   function automatic void store_word(input logic [5:0] a, input logic [31:0] d,
                                      input logic low);
      logic [38:0] cw;
      cw = model_encode(d);
      if (low && inj_double_m) begin
         cw[1:0] = ~cw[1:0];
      end else if (low && inj_single_m) begin
         cw[0] = ~cw[0];
      end
      shadow[a] = cw;
   endfunction

   function automatic exp_t expected_line(input logic [5:0] a);
      exp_t        e;
      logic [33:0] r;
      e = '0;
      for (int l = 0; l < ICCM_LANES; l++) begin
         r = model_decode(shadow[{a[5:2], 2'(l)}], correct_en_m);
         e.data[l*32 +: 32] = r[31:0];
         e.sgl = e.sgl | r[32];
         e.dbl = e.dbl | r[33];
      end
      return e;
   endfunction

   task automatic write_word(input logic [5:0] a, input logic [31:0] d);
      @(posedge clk);
      wr_en    <= 1'b1;
      wr_dword <= 1'b0;
      addr     <= ADDR_W'(a);
      wr_data  <= {32'h0, d};
      store_word(a, d, 1'b1);
      inj_single_m = 1'b0;
      inj_double_m = 1'b0;
      @(posedge clk);
      wr_en <= 1'b0;
   endtask

   // Low half to the even lane of the pair picked by addr[1]
   task automatic write_dword(input logic [5:0] a, input logic [63:0] d);
      logic [5:0] base;
      base = {a[5:2], a[1], 1'b0};
      @(posedge clk);
      wr_en    <= 1'b1;
      wr_dword <= 1'b1;
      addr     <= ADDR_W'(a);
      wr_data  <= d;
      store_word(base, d[31:0], 1'b1);
      store_word(base + 6'd1, d[63:32], 1'b0);
      inj_single_m = 1'b0;
      inj_double_m = 1'b0;
      @(posedge clk);
      wr_en <= 1'b0;
   endtask

   task automatic read_line(input logic [5:0] a);
      @(posedge clk);
      rd_en <= 1'b1;
      addr  <= ADDR_W'(a);
      exp_q.push_back(expected_line(a));
      @(posedge clk);
      rd_en <= 1'b0;
   endtask

   task automatic read_pair(input logic [5:0] a, input logic [5:0] b);
      @(posedge clk);
      rd_en <= 1'b1;
      addr  <= ADDR_W'(a);
      exp_q.push_back(expected_line(a));
      @(posedge clk);
      addr <= ADDR_W'(b);
      exp_q.push_back(expected_line(b));
      @(posedge clk);
      rd_en <= 1'b0;
   endtask

   task automatic wait_reads_done();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         fail_now("timed out waiting for rd_valid");
      end
   endtask

   task automatic csr_write(input logic [1:0] a, input logic [31:0] v);
      @(posedge clk);
      csr_wr    <= 1'b1;
      csr_addr  <= a;
      csr_wdata <= v;
      if (a == 2'd0) begin
         correct_en_m = v[0];
         inj_single_m = v[1];
         inj_double_m = v[2];
      end
      @(posedge clk);
      csr_wr <= 1'b0;
   endtask

   task automatic csr_check(input logic [1:0] a, input logic [31:0] v, input string name);
      @(posedge clk);
      csr_addr <= a;
      @(negedge clk);
      check_val(name, v, csr_rdata);
   endtask

   //**************************************************
   // Read checker, one cycle latency from rd_en
   //**************************************************

   always @(negedge clk) begin : compare_reads
      exp_t e;
      check_val("rd_valid latency", rd_en_prev, rd_valid);
      rd_en_prev = rd_en;
      if (rd_valid) begin
         if (exp_q.size() == 0) begin
            fail_now("rd_valid came with no read pending");
         end else begin
            e = exp_q.pop_front();
            check_val("rd_data", e.data, rd_data);
            check_val("rd_single_err", e.sgl, rd_single_err);
            check_val("rd_double_err", e.dbl, rd_double_err);
         end
      end
   end

   initial begin : main
      logic [5:0]  a;
      logic [31:0] d;
      seed         = 22;
      reset        = 1'b1;
      wr_en        = 1'b0;
      rd_en        = 1'b0;
      addr         = '0;
      wr_dword     = 1'b0;
      wr_data      = '0;
      csr_wr       = 1'b0;
      csr_addr     = 2'd0;
      csr_wdata    = '0;
      correct_en_m = 1'b1;
      inj_single_m = 1'b0;
      inj_double_m = 1'b0;
      rd_en_prev   = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      csr_check(2'd0, 32'd1, "CTRL after reset");
      csr_check(2'd1, 32'd0, "SB_COUNT after reset");
      csr_check(2'd2, 32'd0, "DB_COUNT after reset");
      csr_check(2'd3, 32'd0, "ERR_ADDR after reset");

      for (int i = 0; i < SHADOW_WORDS; i += 2) begin
         write_dword(6'(i), {fill_pattern(i + 1), fill_pattern(i)});
      end

      // Random single-word writes
      for (int i = 0; i < 20; i++) begin
         a = 6'($random(seed));
         d = $random(seed);
         write_word(a, d);
         read_line(a);
         read_line(6'($random(seed)));
         wait_reads_done();
      end

      // Double words, then back-to-back reads across both banks
      for (int i = 0; i < 8; i++) begin
         a = 6'($random(seed));
         write_dword(a, {$random(seed), $random(seed)});
         read_line(a);
         wait_reads_done();
      end
      for (int i = 0; i < 16; i += 2) begin
         read_pair(6'(i * 4), 6'(i * 4 + 4));
         wait_reads_done();
      end

      // Single-bit injection, corrected then raw
      csr_write(2'd0, 32'd3);
      write_word(6'd17, $random(seed));
      read_line(6'd17);
      wait_reads_done();
      csr_check(2'd1, 32'd1, "SB_COUNT after single error");
      csr_check(2'd3, 32'd4, "ERR_ADDR after single error");
      csr_check(2'd0, 32'd1, "CTRL after single injection");
      csr_write(2'd0, 32'd0);
      read_line(6'd17);
      wait_reads_done();
      csr_check(2'd1, 32'd2, "SB_COUNT after raw read");

      // Double-bit injection
      csr_write(2'd0, 32'd5);
      write_word(6'd42, $random(seed));
      csr_check(2'd0, 32'd1, "CTRL after double injection");
      read_line(6'd42);
      wait_reads_done();
      csr_check(2'd2, 32'd1, "DB_COUNT after double error");
      csr_check(2'd3, 32'd10, "ERR_ADDR after double error");

      // Clear on write
      csr_write(2'd1, 32'hFFFF_FFFF);
      csr_write(2'd2, 32'd3);
      csr_write(2'd3, 32'd7);
      read_line(6'd0);
      wait_reads_done();
      csr_check(2'd1, 32'd0, "SB_COUNT after clear");
      csr_check(2'd2, 32'd0, "DB_COUNT after clear");
      csr_check(2'd3, 32'd0, "ERR_ADDR after clear");

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+dv
design/iccm_pkg.sv
design/iccm_ram.sv
design/iccm_ecc_gen.sv
design/iccm_ecc_chk.sv
design/iccm_mem.sv
design/iccm_csr.sv
design/iccm_top.sv
dv/iccm_tb.sv
